//--- common/devBoardPkg.sv
package devBoardPkg;

	// One host bus cycle as seen at the board edge
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        rd;
		logic        wr;
		logic [1:0]  byteEn;    // Bit 0 is WR0N, bit 1 is WR1N
	} hostReq_t;

	typedef struct packed {
		logic [15:0] rdata;
		logic        rdValid;
	} hostRsp_t;

	// Per-peripheral slice of a host cycle
	typedef struct packed {
		logic [2:0]  regOffset; // Word offset inside the region
		logic [15:0] wdata;
		logic [1:0]  byteEn;
		logic        rd;
		logic        wr;
		logic        sel;
	} periphReq_t;

	localparam logic [15:0] addrLed        = 16'h0000;
	localparam logic [15:0] addrDip        = 16'h0002;
	localparam logic [15:0] addrIntPending = 16'h0010;
	localparam logic [15:0] addrIntMask    = 16'h0012;

	// Regions are 16 bytes each
	localparam int          regionBits = 4;
	localparam logic [15:0] gpioBase   = 16'h0000;
	localparam logic [15:0] intBase    = 16'h0010;

	// Word offsets as they arrive in regOffset
	localparam logic [2:0] offLed        = addrLed[regionBits-1:1];
	localparam logic [2:0] offDip        = addrDip[regionBits-1:1];
	localparam logic [2:0] offIntPending = addrIntPending[regionBits-1:1];
	localparam logic [2:0] offIntMask    = addrIntMask[regionBits-1:1];

	localparam int numIntSrc  = 8;
	localparam int numIntPins = 7; // INT0..INT6
	localparam int intSrcDip  = 7;

endpackage

//--- design/busDecoder.sv
module busDecoder (
	input  logic                   clk,
	input  logic                   rstN,
	input  devBoardPkg::hostReq_t  req,
	input  logic [15:0]            gpioRdata,
	input  logic [15:0]            intRdata,
	output devBoardPkg::periphReq_t gpioReq,
	output devBoardPkg::periphReq_t intReq,
	output devBoardPkg::hostRsp_t  rsp
);
	import devBoardPkg::*;

	logic        gpioHit;
	logic        intHit;
	logic [15:0] rdWord;
	logic [15:0] rdataQ;
	logic        rdValidQ;

	// Strobes only reach the peripheral whose region matched
	function automatic periphReq_t makeReq(input hostReq_t r, input logic hit);
		periphReq_t p;
		p.regOffset = r.addr[regionBits-1:1];
		p.wdata     = r.wdata;
		p.byteEn    = r.byteEn;
		p.rd        = r.rd & hit;
		p.wr        = r.wr & hit;
		p.sel       = hit;
		return p;
	endfunction

	assign gpioHit = (req.addr[15:regionBits] == gpioBase[15:regionBits]);
	assign intHit  = (req.addr[15:regionBits] == intBase[15:regionBits]);

	assign gpioReq = makeReq(req, gpioHit);
	assign intReq  = makeReq(req, intHit);

	always_comb begin
		rdWord = '0; // Unmapped reads return zero
		if (gpioHit)
			rdWord = gpioRdata;
		else if (intHit)
			rdWord = intRdata;
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			rdValidQ <= 1'b0;
		else
			rdValidQ <= req.rd;
	end

	// Read word holds until the next read
	always_ff @(posedge clk) begin
		if (req.rd)
			rdataQ <= rdWord;
	end

	assign rsp.rdata   = rdataQ;
	assign rsp.rdValid = rdValidQ;

	// Host must never issue a read and a write in the same cycle
	rdWrExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(req.rd && req.wr));

endmodule

//--- design/devBoard.sv
module devBoard (
	input  logic                                 clk,
	input  logic                                 rstN,
	input  devBoardPkg::hostReq_t                req,
	input  logic [3:0]                           dipSw,
	input  logic [devBoardPkg::numIntPins-1:0]   intPins,
	output devBoardPkg::hostRsp_t                rsp,
	output logic [7:0]                           led,
	output logic                                 irq
);
	import devBoardPkg::*;

	periphReq_t  gpioReq;
	periphReq_t  intReq;
	logic [15:0] gpioRdata;
	logic [15:0] intRdata;
	logic        dipChange;  // GPIO to interrupt source 7

	busDecoder busDecoder_i (
		.clk       (clk),
		.rstN      (rstN),
		.req       (req),
		.gpioRdata (gpioRdata),
		.intRdata  (intRdata),
		.gpioReq   (gpioReq),
		.intReq    (intReq),
		.rsp       (rsp)
	);

	// LEDs and DIP switches
	gpioPort gpioPort_i (
		.clk       (clk),
		.rstN      (rstN),
		.req       (gpioReq),
		.dipSw     (dipSw),
		.rdata     (gpioRdata),
		.led       (led),
		.dipChange (dipChange)
	);

	// INT0..INT6 plus the DIP change
	intController intController_i (
		.clk       (clk),
		.rstN      (rstN),
		.req       (intReq),
		.intPins   (intPins),
		.dipChange (dipChange),
		.rdata     (intRdata),
		.irq       (irq)
	);

endmodule

//--- gpio/gpioPort.sv
module gpioPort (
	input  logic                    clk,
	input  logic                    rstN,
	input  devBoardPkg::periphReq_t req,
	input  logic [3:0]              dipSw,
	output logic [15:0]             rdata,
	output logic [7:0]              led,
	output logic                    dipChange
);
	import devBoardPkg::*;

	logic [7:0] ledQ;
	logic [3:0] dipMeta;
	logic [3:0] dipSync;
	logic [3:0] dipPrev;
	logic       dipChangeQ;
	logic       ledWrite;

	// High byte of a write is ignored
	assign ledWrite = req.sel && req.wr && req.byteEn[0] && (req.regOffset == offLed);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ledQ <= '0;
		end else if (ledWrite) begin
			ledQ <= req.wdata[7:0];
		end
	end

	// Two-flop synchronizer, then one more stage for the change compare
	always_ff @(posedge clk) begin
		if (!rstN) begin
			dipMeta    <= '0;
			dipSync    <= '0;
			dipPrev    <= '0;
			dipChangeQ <= 1'b0;
		end else begin
			dipMeta    <= dipSw;
			dipSync    <= dipMeta;
			dipPrev    <= dipSync;
			dipChangeQ <= (dipSync != dipPrev); // One-cycle pulse per change
		end
	end

	always_comb begin
		rdata = '0;
		if (req.sel && req.rd) begin
			case (req.regOffset)
				offLed:  rdata = {8'h00, ledQ};
				offDip:  rdata = {12'h000, dipSync};
				default: rdata = '0;
			endcase
		end
	end

	assign led       = ledQ;
	assign dipChange = dipChangeQ;

	// LEDs move only on a selected low-byte write
	ledOnlyOnWrite: assert property (@(posedge clk) disable iff (!rstN)
		!ledWrite |=> $stable(led));

endmodule

//--- intCtrl/intController.sv
module intController (
	input  logic                                 clk,
	input  logic                                 rstN,
	input  devBoardPkg::periphReq_t              req,
	input  logic [devBoardPkg::numIntPins-1:0]   intPins,
	input  logic                                 dipChange,
	output logic [15:0]                          rdata,
	output logic                                 irq
);
	import devBoardPkg::*;

	logic [numIntPins-1:0] pinMeta;
	logic [numIntPins-1:0] pinSync;
	logic [numIntPins-1:0] pinPrev;   // Edge register
	logic [numIntSrc-1:0]  newEdges;
	logic [numIntSrc-1:0]  clearBits;
	logic [numIntSrc-1:0]  pendingQ;
	logic [numIntSrc-1:0]  maskQ;
	logic                  irqQ;
	logic                  lowByteWr;
	logic                  maskWrite;

	assign lowByteWr = req.sel && req.wr && req.byteEn[0];
	assign maskWrite = lowByteWr && (req.regOffset == offIntMask);

	// Write-one-to-clear on the pending register
	assign clearBits = (lowByteWr && (req.regOffset == offIntPending)) ?
		req.wdata[numIntSrc-1:0] : '0;

	// Pins fill the low sources, DIP change sits on its own index
	always_comb begin
		newEdges = '0;
		newEdges[numIntPins-1:0] = pinSync & ~pinPrev;
		newEdges[intSrcDip] = dipChange;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pinMeta <= '0;
			pinSync <= '0;
			pinPrev <= '0;
		end else begin
			pinMeta <= intPins;
			pinSync <= pinMeta;
			pinPrev <= pinSync;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pendingQ <= '0;
		end else begin
			pendingQ <= (pendingQ & ~clearBits) | newEdges; // New edge beats clear
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			maskQ <= '0;
		end else if (maskWrite) begin
			maskQ <= req.wdata[numIntSrc-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			irqQ <= 1'b0;
		else
			irqQ <= |(pendingQ & maskQ);
	end

	always_comb begin
		rdata = '0;
		if (req.sel && req.rd) begin
			case (req.regOffset)
				offIntPending: rdata = {8'h00, pendingQ};
				offIntMask:    rdata = {8'h00, maskQ};
				default:       rdata = '0;
			endcase
		end
	end

	assign irq = irqQ;

	// Request line drops a cycle after the last unmasked bit goes
	irqFollowsMask: assert property (@(posedge clk) disable iff (!rstN)
		((pendingQ & maskQ) == '0) |=> !irq);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the devBoard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module devBoardTb -o simDevBoard

# A failing run still prints its output before the verdict
out=$(./obj_dir/simDevBoard 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi

//--- sim.f
common/devBoardPkg.sv
design/busDecoder.sv
gpio/gpioPort.sv
intCtrl/intController.sv
design/devBoard.sv
verification/devBoardTb.sv

//--- verification/devBoardTb.sv
module devBoardTb;
	timeunit 1ns;
	timeprecision 1ns;
	import devBoardPkg::*;

	localparam int clkPeriod = 40;
	// Reset, unmapped, LED, back-to-back, DIP, pins, clear, drain
	localparam int plannedCycles = 3 + 2 + 115 + 11 + 80 + 66 + 16 + 2;

	logic                  clk;
	logic                  rstN;
	hostReq_t              req;
	hostRsp_t              rsp;
	logic [3:0]            dipSw;
	logic [numIntPins-1:0] intPins;
	logic [7:0]            led;
	logic                  irq;

	integer seed;
	string  testName;

	// Reference register model
	logic [7:0]            ledModel;
	logic [7:0]            maskModel;
	logic [7:0]            pendModel;
	logic [3:0]            dipModel;
	logic [numIntPins-1:0] pinsModel;

	logic [15:0] expQ[$];   // Expected read words in issue order
	time         issueQ[$];

	devBoard dut_i (
		.clk     (clk),
		.rstN    (rstN),
		.req     (req),
		.dipSw   (dipSw),
		.intPins (intPins),
		.rsp     (rsp),
		.led     (led),
		.irq     (irq)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] nextRand();
		return $random(seed);
	endfunction

	function automatic logic [15:0] refRead(input logic [15:0] addr);
		case (addr)
			addrLed:        return {8'h00, ledModel};
			addrDip:        return {12'h000, dipModel};
			addrIntPending: return {8'h00, pendModel};
			addrIntMask:    return {8'h00, maskModel};
			default:        return 16'h0000; // Unmapped
		endcase
	endfunction

	function automatic void refWrite(input logic [15:0] addr, input logic [15:0] data,
			input logic [1:0] be);
		if (be[0]) begin // Only low-byte registers exist
			case (addr)
				addrLed:        ledModel = data[7:0];
				addrIntPending: pendModel = pendModel & ~data[7:0];
				addrIntMask:    maskModel = data[7:0];
				default:        ;
			endcase
		end
	endfunction

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkRsp(input string name, input hostRsp_t exp, input hostRsp_t act);
		if (act !== exp)
			reportFailure($sformatf(
				"** Error %s: expected rdata %h valid %b, actual rdata %h valid %b",
				name, exp.rdata, exp.rdValid, act.rdata, act.rdValid));
	endtask

	task automatic checkLed(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			reportFailure($sformatf("** Error %s: expected led %h, actual led %h",
				name, exp, act));
	endtask

	task automatic checkIrq(input string name, input logic exp, input logic act);
		if (act !== exp)
			reportFailure($sformatf("** Error %s: expected irq %b, actual irq %b",
				name, exp, act));
	endtask

	task automatic busWrite(input logic [15:0] addr, input logic [15:0] data,
			input logic [1:0] be);
		hostReq_t cyc;
		@(negedge clk);
		cyc = '0;
		cyc.addr = addr;
		cyc.wdata = data;
		cyc.wr = 1'b1;
		cyc.byteEn = be;
		req = cyc;
		refWrite(addr, data, be);
	endtask

	task automatic busRead(input logic [15:0] addr);
		hostReq_t cyc;
		@(negedge clk);
		cyc = '0;
		cyc.addr = addr;
		cyc.rd = 1'b1;
		req = cyc;
		expQ.push_back(refRead(addr));
		issueQ.push_back($time);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			req = '0;
		end
	endtask

	task automatic ledPattern(input logic [15:0] data);
		busWrite(addrLed, data, 2'b11);
		idle(1);
		checkLed(testName, data[7:0], led);
		busRead(addrLed);
		idle(2);
	endtask

	// Read returns are checked one cycle after issue
	always @(negedge clk) begin : compareReads
		hostRsp_t exp;
		if (rsp.rdValid === 1'b1) begin
			if (expQ.size() == 0) begin
				reportFailure("rdValid went high with no read outstanding");
			end else begin
				exp.rdata = expQ.pop_front();
				exp.rdValid = 1'b1;
				void'(issueQ.pop_front());
				checkRsp(testName, exp, rsp);
			end
		end else if (issueQ.size() > 0 && issueQ[0] < $time) begin
			reportFailure($sformatf("Read issued at %0t got no rdValid one cycle later",
				issueQ[0]));
		end
	end

	initial begin : watchdog
		#(plannedCycles * 2 * clkPeriod);
		$display("Watchdog expired after %0d cycles, the run hung", plannedCycles * 2);
		$display("test failed");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] r;
		seed = 32'ha846_8e08;
		clk = 1'b0;
		rstN = 1'b0;
		req = '0;
		dipSw = '0;
		intPins = '0;
		ledModel = '0;
		maskModel = '0;
		pendModel = '0;
		dipModel = '0;
		pinsModel = '0;
		testName = "reset";
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		checkLed(testName, 8'h00, led);
		checkIrq(testName, 1'b0, irq);

		testName = "unmapped";
		busWrite(16'h0100, 16'hFFFF, 2'b11);
		idle(1);
		checkLed(testName, 8'h00, led);

		testName = "ledWrite";
		ledPattern(16'hAAAA);
		ledPattern(16'h5555);
		repeat (20) begin
			r = nextRand();
			ledPattern(r[15:0]);
		end
		busWrite(addrLed, {8'h00, ~ledModel}, 2'b10); // High lane only so LED must hold
		idle(1);
		checkLed(testName, ledModel, led);
		busRead(addrLed);
		idle(2);

		// Unmapped reads sit among live registers so an alias would show
		testName = "backToBack";
		busWrite(addrIntMask, 16'h00C3, 2'b01);
		busRead(addrLed);
		busRead(addrIntMask);
		busRead(16'h0112);
		busRead(addrDip);
		busRead(16'h8000);
		busRead(addrLed);
		busRead(addrIntPending);
		idle(2);

		testName = "dipSwitch";
		repeat (8) begin
			r = nextRand();
			@(negedge clk);
			dipSw = r[3:0];
			if (r[3:0] != dipModel)
				pendModel[intSrcDip] = 1'b1;
			dipModel = r[3:0];
			idle(5); // Sync, change pulse and pending set
			busRead(addrDip);
			busRead(addrIntPending);
			idle(2);
		end

		testName = "intPins";
		repeat (6) begin
			r = nextRand();
			busWrite(addrIntMask, {8'h00, r[15:8]}, 2'b01);
			idle(1);
			pendModel[numIntPins-1:0] = pendModel[numIntPins-1:0] | (r[6:0] & ~pinsModel);
			pinsModel = r[6:0];
			intPins = r[6:0];
			idle(5);
			busRead(addrIntPending);
			busRead(addrIntMask);
			idle(2);
			checkIrq(testName, |(pendModel & maskModel), irq);
		end

		// Pins stay put from here, so no new edges
		testName = "intClear";
		busWrite(addrIntMask, 16'h000F, 2'b01);
		r = nextRand();
		busWrite(addrIntPending, {8'h00, r[7:0]}, 2'b01);
		idle(1);
		busRead(addrIntPending);
		idle(2);
		checkIrq(testName, |(pendModel & maskModel), irq);
		busWrite(addrIntPending, {8'h00, pendModel & maskModel}, 2'b01);
		idle(3);
		checkIrq(testName, 1'b0, irq);
		busRead(addrIntPending);
		idle(2);

		if (expQ.size() != 0) begin
			reportFailure("Reads still outstanding at the end of the run");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule
